// File: logic/opn_pkg.sv
// FM sound chip register front end definitions

package opn_pkg;

    // Register numbers, part 0 unless noted
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTRL = 8'h27;
    localparam logic [7:0] REG_DAC_DATA   = 8'h2A;
    localparam logic [7:0] REG_DAC_EN     = 8'h2B;
    localparam logic [7:0] REG_PAN_CH6    = 8'hB6;  // Part 1

    localparam int TIMER_B_PRESCALE = 16;  // Sample ticks per timer B step
    localparam int DAC_SHIFT        = 6;

    typedef logic [9:0]        timer_a_t;
    typedef logic [7:0]        timer_b_t;
    typedef logic signed [15:0] sample_t;

    // Register 0x27
    typedef struct packed {
        logic [1:0] ch3_mode;  // Special mode for channel 3, not modelled
        logic       clr_b;
        logic       clr_a;
        logic       en_b;
        logic       en_a;
        logic       load_b;
        logic       load_a;
    } timer_ctrl_t;

    // Register 0xB6
    typedef struct packed {
        logic       left;
        logic       right;
        logic [5:0] sens;      // AMS and PMS, no LFO here
    } pan_ctrl_t;

    // One data byte, read according to the latched register number
    typedef union packed {
        logic [7:0]  raw;
        timer_ctrl_t tmr;
        pan_ctrl_t   pan;
    } reg_word_u;

endpackage

// File: logic/timer_ctrl_if.sv
// Timer control interface
`timescale 1ns/100ps

interface timer_ctrl_if;

    opn_pkg::timer_a_t value_a;
    opn_pkg::timer_b_t value_b;
    logic              load_a;   // Levels from register 0x27
    logic              load_b;
    logic              en_a;
    logic              en_b;
    logic              clr_a;    // One clock strobes
    logic              clr_b;

    modport decoder (
        output value_a, value_b, load_a, load_b, en_a, en_b, clr_a, clr_b
    );

    modport timers (
        input value_a, value_b, load_a, load_b, en_a, en_b, clr_a, clr_b
    );

endinterface

// File: logic/dac_ctrl_if.sv
// Channel 6 DAC control interface
`timescale 1ns/100ps

interface dac_ctrl_if;

    logic [7:0] dac_data;  // Unsigned, 0x80 is silence
    logic       dac_en;
    logic       pan_l;
    logic       pan_r;

    modport decoder (
        output dac_data,
        output dac_en,
        output pan_l,
        output pan_r
    );

    // Output stage only samples these
    modport output_stage (
        input dac_data,
        input dac_en,
        input pan_l,
        input pan_r
    );

endinterface

// File: logic/opn_reg_decode.sv
// Host bus register decoder
`timescale 1ns/100ps

module opn_reg_decode #(
    parameter int BUSY_CEN = 32
) (
    input  logic          zero,
    input  logic          rst_n,
    input  logic          cen,
    input  logic [7:0]    din,
    input  logic [1:0]    addr,
    input  logic          cs_n,
    input  logic          wr_n,
    output logic          busy,
    timer_ctrl_if.decoder tmr,
    dac_ctrl_if.decoder   dac
);

    localparam int BW = $clog2(BUSY_CEN + 1);

    logic [7:0]         reg_addr;   // Latched register number
    logic               part;       // 0 for channels 1-3, 1 for 4-6
    logic [7:0]         timer_a_hi;
    logic [1:0]         timer_a_lo;
    logic [BW-1:0]      busy_cnt;
    logic               addr_wr;
    logic               data_wr;
    opn_pkg::reg_word_u word;

    assign addr_wr  = ~cs_n & ~wr_n & ~addr[0];
    assign data_wr  = ~cs_n & ~wr_n &  addr[0];
    assign word.raw = din;

    // Address port
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            reg_addr <= '0;
            part     <= 1'b0;
        end else if (addr_wr) begin
            reg_addr <= din;
            part     <= addr[1];
        end
    end

    // Timer registers and clear strobes
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            timer_a_hi  <= '0;
            timer_a_lo  <= '0;
            tmr.value_b <= '0;
            tmr.load_a  <= 1'b0;
            tmr.load_b  <= 1'b0;
            tmr.en_a    <= 1'b0;
            tmr.en_b    <= 1'b0;
            tmr.clr_a   <= 1'b0;
            tmr.clr_b   <= 1'b0;
        end else begin
            tmr.clr_a <= 1'b0;
            tmr.clr_b <= 1'b0;
            if (data_wr && !part) begin
                case (reg_addr)
                    opn_pkg::REG_TIMER_A_HI: timer_a_hi  <= word.raw;
                    opn_pkg::REG_TIMER_A_LO: timer_a_lo  <= word.raw[1:0];
                    opn_pkg::REG_TIMER_B:    tmr.value_b <= word.raw;
                    opn_pkg::REG_TIMER_CTRL: begin
                        tmr.load_a <= word.tmr.load_a;
                        tmr.load_b <= word.tmr.load_b;
                        tmr.en_a   <= word.tmr.en_a;
                        tmr.en_b   <= word.tmr.en_b;
                        tmr.clr_a  <= word.tmr.clr_a;
                        tmr.clr_b  <= word.tmr.clr_b;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign tmr.value_a = {timer_a_hi, timer_a_lo};  // 8 MSBs in 0x24

    // DAC enable and channel 6 panning
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            dac.dac_en <= 1'b0;
            dac.pan_l  <= 1'b1;
            dac.pan_r  <= 1'b1;
        end else if (data_wr) begin
            if (!part && reg_addr == opn_pkg::REG_DAC_EN) begin
                dac.dac_en <= word.raw[7];
            end
            if (part && reg_addr == opn_pkg::REG_PAN_CH6) begin
                dac.pan_l <= word.pan.left;
                dac.pan_r <= word.pan.right;
            end
        end
    end

    always_ff @(posedge zero) begin
        if (data_wr && !part && reg_addr == opn_pkg::REG_DAC_DATA) begin
            dac.dac_data <= word.raw;
        end
    end

    // Busy flag, a new data write restarts the count
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= BW'(BUSY_CEN);
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == BW'(1)) begin
                busy <= 1'b0;            // Last enable pulse of the count
            end
        end
    end

endmodule

// File: logic/opn_timers.sv
// Sample timebase and timers A and B
`timescale 1ns/100ps

module opn_timers #(
    parameter int SAMPLE_DIV = 144
) (
    input  logic         zero,
    input  logic         rst_n,
    input  logic         cen,
    timer_ctrl_if.timers tmr,
    output logic         sample_tick,
    output logic         flag_a,
    output logic         flag_b,
    output logic         irq_n
);

    localparam int DW = $clog2(SAMPLE_DIV + 1);
    localparam int PW = $clog2(opn_pkg::TIMER_B_PRESCALE);

    logic [DW-1:0]     div_cnt;
    logic [PW-1:0]     pre_b;
    opn_pkg::timer_a_t cnt_a;
    opn_pkg::timer_b_t cnt_b;
    logic              step_b;
    logic              ovf_a;
    logic              ovf_b;

    // Sample tick, one clock wide
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= 1'b0;
            if (cen) begin
                if (div_cnt == DW'(SAMPLE_DIV - 1)) begin
                    div_cnt     <= '0;
                    sample_tick <= 1'b1;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    assign step_b = sample_tick && pre_b == PW'(opn_pkg::TIMER_B_PRESCALE - 1);
    assign ovf_a  = tmr.load_a && sample_tick && cnt_a == '1;
    assign ovf_b  = tmr.load_b && step_b && cnt_b == '1;

    // Timer A counts sample ticks up to 1023
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            cnt_a <= '0;
        end else if (!tmr.load_a || ovf_a) begin
            cnt_a <= tmr.value_a;        // Hold or reload
        end else if (sample_tick) begin
            cnt_a <= cnt_a + 1'b1;
        end
    end

    // Timer B, one step per prescaler wrap
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            pre_b <= '0;
            cnt_b <= '0;
        end else if (!tmr.load_b) begin
            pre_b <= '0;                 // Prescaler restarts on load
            cnt_b <= tmr.value_b;
        end else if (sample_tick) begin
            pre_b <= step_b ? '0 : pre_b + 1'b1;
            if (ovf_b) begin
                cnt_b <= tmr.value_b;
            end else if (step_b) begin
                cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // Status flags, clear wins over a new overflow
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (tmr.clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && tmr.en_a) begin
                flag_a <= 1'b1;
            end
            if (tmr.clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && tmr.en_b) begin
                flag_b <= 1'b1;
            end
        end
    end

    assign irq_n = ~(flag_a | flag_b);

endmodule

// File: logic/opn_dac_out.sv
// Channel 6 DAC output stage
`timescale 1ns/100ps

module opn_dac_out (
    input  logic                    zero,
    input  logic                    rst_n,
    input  logic                    sample_tick,
    dac_ctrl_if.output_stage        dac,
    output opn_pkg::sample_t        snd_left,
    output opn_pkg::sample_t        snd_right
);

    localparam int SW = $bits(opn_pkg::sample_t);

    logic signed [7:0] centred;
    opn_pkg::sample_t  dac_sample;

    // Byte minus 128, same as flipping the MSB
    assign centred = {~dac.dac_data[7], dac.dac_data[6:0]};

    assign dac_sample = {
        {(SW - 8 - opn_pkg::DAC_SHIFT){centred[7]}},   // Sign extension
        centred,
        {opn_pkg::DAC_SHIFT{1'b0}}
    };

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            snd_left  <= '0;
            snd_right <= '0;
        end else if (sample_tick) begin
            // Disabled DAC gives silence on both sides
            snd_left  <= (dac.dac_en && dac.pan_l) ? dac_sample : '0;
            snd_right <= (dac.dac_en && dac.pan_r) ? dac_sample : '0;
        end
    end

endmodule

// File: logic/opn_top.sv
// FM sound chip register front end
`timescale 1ns/100ps

module opn_top #(
    parameter int SAMPLE_DIV = 144,  // Enable pulses per output sample
    parameter int BUSY_CEN   = 32
) (
    input  logic             zero,
    input  logic             rst_n,
    input  logic             cen,
    input  logic [7:0]       din,
    input  logic [1:0]       addr,
    input  logic             cs_n,
    input  logic             wr_n,
    output logic [7:0]       dout,
    output logic             irq_n,
    output opn_pkg::sample_t snd_left,
    output opn_pkg::sample_t snd_right,
    output logic             snd_sample
);

    logic busy;
    logic flag_a;
    logic flag_b;
    logic sample_tick;

    timer_ctrl_if tmr_bus ();
    dac_ctrl_if   dac_bus ();

    opn_reg_decode #(
        .BUSY_CEN ( BUSY_CEN )
    ) u_reg_decode (
        .zero   ( zero    ),
        .rst_n  ( rst_n   ),
        .cen    ( cen     ),
        .din    ( din     ),
        .addr   ( addr    ),
        .cs_n   ( cs_n    ),
        .wr_n   ( wr_n    ),
        .busy   ( busy    ),
        .tmr    ( tmr_bus ),
        .dac    ( dac_bus )
    );

    opn_timers #(
        .SAMPLE_DIV ( SAMPLE_DIV )
    ) u_timers (
        .zero        ( zero        ),
        .rst_n       ( rst_n       ),
        .cen         ( cen         ),
        .tmr         ( tmr_bus     ),
        .sample_tick ( sample_tick ),
        .flag_a      ( flag_a      ),
        .flag_b      ( flag_b      ),
        .irq_n       ( irq_n       )
    );

    opn_dac_out u_dac_out (
        .zero        ( zero        ),
        .rst_n       ( rst_n       ),
        .sample_tick ( sample_tick ),
        .dac         ( dac_bus     ),
        .snd_left    ( snd_left    ),
        .snd_right   ( snd_right   )
    );

    // Status read is the same on every address
    assign dout       = {busy, 5'd0, flag_b, flag_a};
    assign snd_sample = sample_tick;

endmodule

// File: test/opn_model.svh
// Register front end reference model
`ifndef OPN_MODEL_SVH
`define OPN_MODEL_SVH

logic [9:0] m_timer_a;
logic [7:0] m_timer_b;
logic [7:0] m_dac_byte;
logic       m_dac_en;
logic       m_pan_l;
logic       m_pan_r;

// Values that hold after reset
task automatic model_reset();
    m_timer_a  = '0;
    m_timer_b  = '0;
    m_dac_byte = 8'h80;
    m_dac_en   = 1'b0;
    m_pan_l    = 1'b1;
    m_pan_r    = 1'b1;
endtask

// Register write as the host sees it
task automatic model_write(input logic part, input logic [7:0] reg_num,
                           input logic [7:0] data);
    if (!part) begin
        case (reg_num)
            opn_pkg::REG_TIMER_A_HI: m_timer_a[9:2] = data;
            opn_pkg::REG_TIMER_A_LO: m_timer_a[1:0] = data[1:0];
            opn_pkg::REG_TIMER_B:    m_timer_b = data;
            opn_pkg::REG_DAC_DATA:   m_dac_byte = data;
            opn_pkg::REG_DAC_EN:     m_dac_en = data[7];
            default: ;
        endcase
    end else if (reg_num == opn_pkg::REG_PAN_CH6) begin
        m_pan_l = data[7];
        m_pan_r = data[6];
    end
endtask

// Sample ticks from load to the first overflow
function automatic int model_timer_a_ticks();
    return 1024 - int'(m_timer_a);
endfunction

function automatic int model_timer_b_ticks();
    return 16 * (256 - int'(m_timer_b));
endfunction

// Centred byte scaled by 64
function automatic logic signed [15:0] model_dac_sample(input logic pan);
    int value;
    value = (int'(m_dac_byte) - 128) * 64;
    if (m_dac_en && pan) begin
        return value[15:0];
    end
    return '0;
endfunction

`endif

// File: test/opn_tb.sv
// Register front end testbench
`timescale 1ns/100ps

module opn_tb;

    localparam int SAMPLE_DIV = 8;
    localparam int BUSY_CEN   = 32;

    logic             zero;
    logic             rst_n;
    logic             cen;
    logic [7:0]       din;
    logic [1:0]       addr;
    logic             cs_n;
    logic             wr_n;
    logic [7:0]       dout;
    logic             irq_n;
    opn_pkg::sample_t snd_left;
    opn_pkg::sample_t snd_right;
    logic             snd_sample;

    `include "opn_model.svh"

    opn_top #(
        .SAMPLE_DIV ( SAMPLE_DIV ),
        .BUSY_CEN   ( BUSY_CEN   )
    ) i_opn_top (
        .zero       ( zero       ),
        .rst_n      ( rst_n      ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        zero = 1'b0;
        forever #2 zero = ~zero;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("** Error at %0t: %s, got %0h expected %0h", $time, msg,
                     actual, expected);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // One clock address write followed by one clock data write
    task automatic bus_write(input logic part, input logic [7:0] reg_num,
                             input logic [7:0] data);
        @(posedge zero);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= {part, 1'b0};
        din  <= reg_num;
        @(posedge zero);
        addr <= {part, 1'b1};
        din  <= data;
        @(posedge zero);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        model_write(part, reg_num, data);
    endtask

    task automatic wait_busy_clear();
        int n;
        n = 0;
        @(negedge zero);
        while (dout[7]) begin
            if (n > BUSY_CEN + 16) report_timeout("the busy flag to fall");
            check(dout[6:0], 7'h0, "status bits changed during busy");
            n++;
            @(negedge zero);
        end
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        @(negedge zero);
        while (!snd_sample) begin
            if (n > 2 * SAMPLE_DIV + 4) report_timeout("a sample pulse");
            n++;
            @(negedge zero);
        end
    endtask

    // Clocks from one sample pulse to the next with cen held high
    task automatic measure_sample_period();
        int n;
        wait_sample();
        n = 0;
        @(negedge zero);
        while (!snd_sample) begin
            if (n > 2 * SAMPLE_DIV) report_timeout("the next sample pulse");
            n++;
            @(negedge zero);
        end
        check(n + 1, SAMPLE_DIV, "clocks between sample pulses");
    endtask

    // Counts sample pulses until a status bit rises or the pulse limit is hit
    task automatic count_ticks(input int bit_idx, input int max_ticks,
                               output int ticks, output logic seen);
        int n;
        n     = 0;
        ticks = 0;
        seen  = 1'b0;
        while (!seen && ticks < max_ticks) begin
            @(negedge zero);
            if (n > (max_ticks + 4) * SAMPLE_DIV) report_timeout("timer sample pulses");
            if (dout[bit_idx]) seen = 1'b1;
            else if (snd_sample) ticks++;
            n++;
        end
    endtask

    initial begin
        int         value;
        int         ticks;
        logic       seen;
        logic [1:0] pan;
        logic [7:0] byte_val;

        void'($urandom(17));
        model_reset();
        rst_n <= 1'b0;
        cen   <= 1'b1;
        din   <= '0;
        addr  <= '0;
        cs_n  <= 1'b1;
        wr_n  <= 1'b1;
        repeat (16) @(posedge zero);
        rst_n <= 1'b1;
        @(negedge zero);
        check(dout, 8'h00, "status after reset");
        check(irq_n, 1'b1, "irq_n after reset");
        check(snd_left, 16'h0, "left after reset");
        check(snd_right, 16'h0, "right after reset");
        measure_sample_period();

        // Busy follows a data write
        bus_write(1'b0, opn_pkg::REG_DAC_DATA, 8'($urandom));
        @(negedge zero);
        check(dout, 8'h80, "busy one clock after write");
        wait_busy_clear();

        // Timer A
        value = 1000 + $urandom % 24;
        bus_write(1'b0, opn_pkg::REG_TIMER_A_HI, 8'(value >> 2));
        bus_write(1'b0, opn_pkg::REG_TIMER_A_LO, 8'(value & 3));
        bus_write(1'b0, opn_pkg::REG_TIMER_CTRL, 8'h05);
        count_ticks(0, model_timer_a_ticks() + 4, ticks, seen);
        if (!seen) report_timeout("the timer A flag");
        check(ticks, model_timer_a_ticks(), "timer A overflow ticks");
        check(irq_n, 1'b0, "irq_n with flag A set");
        bus_write(1'b0, opn_pkg::REG_TIMER_CTRL, 8'h10);
        @(posedge zero);
        @(negedge zero);
        check(dout[0], 1'b0, "flag A after clear");
        check(irq_n, 1'b1, "irq_n after clear A");

        // Timer B with and without enable
        value = 250 + $urandom % 6;
        bus_write(1'b0, opn_pkg::REG_TIMER_B, 8'(value));
        bus_write(1'b0, opn_pkg::REG_TIMER_CTRL, 8'h0A);
        count_ticks(1, model_timer_b_ticks() + 4, ticks, seen);
        if (!seen) report_timeout("the timer B flag");
        check(ticks, model_timer_b_ticks(), "timer B overflow ticks");
        bus_write(1'b0, opn_pkg::REG_TIMER_CTRL, 8'h20);
        bus_write(1'b0, opn_pkg::REG_TIMER_CTRL, 8'h02);
        count_ticks(1, 2 * model_timer_b_ticks(), ticks, seen);
        check(seen, 1'b0, "flag B rose with enable off");

        // DAC and panning
        bus_write(1'b0, opn_pkg::REG_DAC_EN, 8'h80);
        repeat (20) begin
            byte_val = 8'($urandom);
            pan      = 2'($urandom);
            bus_write(1'b1, opn_pkg::REG_PAN_CH6, {pan, 6'h0});
            bus_write(1'b0, opn_pkg::REG_DAC_DATA, byte_val);
            wait_busy_clear();
            wait_sample();
            @(negedge zero);
            check(snd_left, model_dac_sample(m_pan_l), "left sample");
            check(snd_right, model_dac_sample(m_pan_r), "right sample");
        end
        bus_write(1'b1, opn_pkg::REG_PAN_CH6, 8'hC0);  // Both sides on
        bus_write(1'b0, opn_pkg::REG_DAC_DATA, 8'hFF);
        bus_write(1'b0, opn_pkg::REG_DAC_EN, 8'h00);
        wait_busy_clear();
        wait_sample();
        @(negedge zero);
        check(snd_left, 16'h0, "left with DAC off");
        check(snd_right, 16'h0, "right with DAC off");

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: project.f
+incdir+test
logic/opn_pkg.sv
logic/timer_ctrl_if.sv
logic/dac_ctrl_if.sv
logic/opn_reg_decode.sv
logic/opn_timers.sv
logic/opn_dac_out.sv
logic/opn_top.sv
test/opn_tb.sv

// File: Bender.yml
package:
  name: opn_front_end

sources:
  - files:
      - logic/opn_pkg.sv
      - logic/timer_ctrl_if.sv
      - logic/dac_ctrl_if.sv
      - logic/opn_reg_decode.sv
      - logic/opn_timers.sv
      - logic/opn_dac_out.sv
      - logic/opn_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/opn_tb.sv
